/* files.f */
hw/adder_pkg.sv
hw/wb_pkg.sv
hw/sklansky_adder.sv
hw/add_sub_unit.sv
hw/wb_adder_regs.sv
hw/wb_adder_top.sv
verif/wb_adder_asserts.sv
verif/tb_wb_adder.sv

/* hw/add_sub_unit.sv */
`timescale 1ns/10ps
// add/subtract datapath around the sklansky adder with flag generation
// a start pulse registers sum and flags into res, res_valid pulses the cycle after

module add_sub_unit
    import adder_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     start,
    input  add_cmd_t cmd,
    output add_res_t res,
    output logic     res_valid
);

    logic                 is_sub;
    logic [ADD_WIDTH-1:0] b_eff;      // second operand as the adder sees it
    logic                 cin_eff;
    logic [ADD_WIDTH-1:0] sum;
    logic                 carry_out;
    add_flags_t           flags;
    add_res_t             next_res;

    assign is_sub = (cmd.op == OP_SUB);

    // a - b is a + ~b + 1, the bus carry-in plays no part
    assign b_eff   = is_sub ? ~cmd.b : cmd.b;
    assign cin_eff = is_sub ? 1'b1 : cmd.carry_in;

    sklansky_adder #(
        .WIDTH (ADD_WIDTH)
    ) i_adder (
        .a         (cmd.a),
        .b         (b_eff),
        .carry_in  (cin_eff),
        .sum       (sum),
        .carry_out (carry_out)
    );

    always_comb begin
        flags.carry    = carry_out;  // 1 means no borrow on subtract
        // both inputs share a sign but the sum does not
        flags.overflow = (cmd.a[ADD_WIDTH-1] == b_eff[ADD_WIDTH-1]) &&
                         (sum[ADD_WIDTH-1] != cmd.a[ADD_WIDTH-1]);
        flags.zero     = (sum == '0);
        flags.negative = sum[ADD_WIDTH-1];
    end

    assign next_res = '{sum: sum, flags: flags};

    // result stage, one launch at a time
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res       <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= start;  // one cycle behind the launch
            if (start) begin
                res <= next_res;
            end
        end
    end

endmodule

/* hw/adder_pkg.sv */
// arithmetic types shared by the add/sub datapath, the register block and the testbench
// import with adder_pkg::* where operands, commands or results are handled

package adder_pkg;

    localparam int ADD_WIDTH = 32;  // operand and result width

    // operation select, bit 0 of the control word
    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } add_op_e;

    // one launched operation
    typedef struct packed {
        add_op_e              op;
        logic                 carry_in;  // ignored for subtract
        logic [ADD_WIDTH-1:0] a;
        logic [ADD_WIDTH-1:0] b;
    } add_cmd_t;

    // flag order matches the FLAGS register, carry in bit 3
    typedef struct packed {
        logic carry;     // carry out of the msb, no borrow on subtract
        logic overflow;  // signed overflow
        logic zero;
        logic negative;  // msb of the sum
    } add_flags_t;

    // registered result of one operation
    typedef struct packed {
        logic [ADD_WIDTH-1:0] sum;
        add_flags_t           flags;
    } add_res_t;

endpackage

/* hw/sklansky_adder.sv */
`timescale 1ns/10ps
// sklansky parallel-prefix adder, purely combinational
// set WIDTH to the operand width; carry_in enters the prefix tree as position zero

module sklansky_adder #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             carry_in,
    output logic [WIDTH-1:0] sum,
    output logic             carry_out
);

    localparam int LEVELS = $clog2(WIDTH);

    logic [WIDTH-1:0] gen_bit;   // per-bit generate
    logic [WIDTH-1:0] half_sum;  // per-bit propagate
    logic [WIDTH-1:0] carry;     // carry into each bit

    // prefix tree, one row per level
    // position 0 holds carry_in, position k holds bit k-1
    wire [WIDTH-1:0] g_lvl [LEVELS+1];
    wire [WIDTH-1:0] p_lvl [LEVELS+1];

    assign gen_bit  = a & b;
    assign half_sum = a ^ b;

    assign g_lvl[0][0] = carry_in;
    assign p_lvl[0][0] = 1'b0;  // nothing sits below carry_in

    for (genvar k = 1; k < WIDTH; k++) begin : g_leaf
        assign g_lvl[0][k] = gen_bit[k-1];
        assign p_lvl[0][k] = half_sum[k-1];
    end

    // divide and conquer: at level l every group of 2^(l+1) positions
    // has its upper half combined with the top of its lower half
    for (genvar l = 0; l < LEVELS; l++) begin : g_level
        for (genvar k = 0; k < WIDTH; k++) begin : g_pos
            if (((k >> l) % 2) == 1) begin : g_cell
                // top position of the lower half
                localparam int J = ((k >> (l + 1)) << (l + 1)) + (1 << l) - 1;

                // prefix combine
                assign g_lvl[l+1][k] = g_lvl[l][k] | (p_lvl[l][k] & g_lvl[l][J]);
                assign p_lvl[l+1][k] = p_lvl[l][k] & p_lvl[l][J];
            end else begin : g_pass
                assign g_lvl[l+1][k] = g_lvl[l][k];
                assign p_lvl[l+1][k] = p_lvl[l][k];
            end
        end
    end

    // last row holds the group generate from each position down to zero
    assign carry = g_lvl[LEVELS];

    assign sum = half_sum ^ carry;

    // carry out from the top bit and the carry into it
    assign carry_out = gen_bit[WIDTH-1] | (half_sum[WIDTH-1] & carry[WIDTH-1]);

endmodule

/* hw/wb_adder_regs.sv */
`timescale 1ns/10ps
// wishbone classic slave with the operand, control, result and status registers
// a write to the control word launches one operation in the datapath

module wb_adder_regs
    import adder_pkg::*;
    import wb_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  wb_req_t  wb_req,
    output wb_rsp_t  wb_rsp,
    output logic     start,
    output add_cmd_t cmd,
    input  add_res_t res,
    input  logic     res_valid
);

    logic                 ack;
    logic                 req_new;    // request seen and not yet acked
    logic                 wr_en;
    logic                 ctrl_wr;
    logic [ADD_WIDTH-1:0] operand_a;
    logic [ADD_WIDTH-1:0] operand_b;
    add_op_e              ctrl_op;
    logic                 ctrl_cin;
    add_res_t             result;     // last completed operation
    logic                 done;
    logic [WB_DAT_W-1:0]  rd_data;

    assign req_new = wb_req.cyc && wb_req.stb && !ack;
    assign wr_en   = req_new && wb_req.we;
    assign ctrl_wr = wr_en && (wb_req.adr == REG_CTRL);

    // single-cycle ack, the !ack term keeps it from repeating
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= req_new;
        end
    end

    // writes take effect on the same edge that raises ack
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            operand_a <= '0;
            operand_b <= '0;
            ctrl_op   <= OP_ADD;
            ctrl_cin  <= 1'b0;
            start     <= 1'b0;
        end else begin
            start <= ctrl_wr;
            if (wr_en) begin
                case (wb_req.adr)
                    REG_OPERAND_A: operand_a <= wb_req.dat;
                    REG_OPERAND_B: operand_b <= wb_req.dat;
                    REG_CTRL: begin
                        ctrl_op  <= wb_req.dat[CTRL_SUB_BIT] ? OP_SUB : OP_ADD;
                        ctrl_cin <= wb_req.dat[CTRL_CIN_BIT];
                    end
                    default: ;  // read-only or unmapped, ignored
                endcase
            end
        end
    end

    // result capture and done flag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
            done   <= 1'b0;
        end else if (res_valid) begin
            result <= res;
            done   <= 1'b1;
        end else if (ctrl_wr) begin
            done <= 1'b0;  // new launch pending
        end
    end

    assign cmd = '{op: ctrl_op, carry_in: ctrl_cin, a: operand_a, b: operand_b};

    // read mux on the held address, so data tracks the registers during ack
    always_comb begin
        rd_data = '0;
        case (wb_req.adr)
            REG_OPERAND_A: rd_data = operand_a;
            REG_OPERAND_B: rd_data = operand_b;
            REG_RESULT:    rd_data = result.sum;
            REG_FLAGS:     rd_data = {{(WB_DAT_W - $bits(add_flags_t)){1'b0}}, result.flags};
            REG_STATUS:    rd_data[STATUS_DONE_BIT] = done;
            default: ;  // control word and unmapped read as zero
        endcase
    end

    assign wb_rsp = '{ack: ack, dat: rd_data};

endmodule

/* hw/wb_adder_top.sv */
`timescale 1ns/10ps
// top level of the wishbone adder peripheral
// connect clk, arst_n and one wishbone classic master

module wb_adder_top
    import adder_pkg::*;
    import wb_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    logic     start;      // launch strobe
    add_cmd_t cmd;
    add_res_t res;
    logic     res_valid;  // result ready for capture

    // bus side registers
    wb_adder_regs i_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .start     (start),
        .cmd       (cmd),
        .res       (res),
        .res_valid (res_valid)
    );

    // arithmetic
    add_sub_unit i_add_sub (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .cmd       (cmd),
        .res       (res),
        .res_valid (res_valid)
    );

endmodule

/* hw/wb_pkg.sv */
// wishbone classic bus structs and the register map of the adder slave
// import with wb_pkg::* in the register block and the testbench

package wb_pkg;

    localparam int WB_ADR_W = 3;   // word address bits
    localparam int WB_DAT_W = 32;

    // master to slave
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    // slave to master, dat is valid while ack is high
    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

    // register word addresses
    localparam logic [WB_ADR_W-1:0] REG_OPERAND_A = WB_ADR_W'(0);  // r/w
    localparam logic [WB_ADR_W-1:0] REG_OPERAND_B = WB_ADR_W'(1);  // r/w
    localparam logic [WB_ADR_W-1:0] REG_CTRL      = WB_ADR_W'(2);  // write launches
    localparam logic [WB_ADR_W-1:0] REG_RESULT    = WB_ADR_W'(3);
    localparam logic [WB_ADR_W-1:0] REG_FLAGS     = WB_ADR_W'(4);
    localparam logic [WB_ADR_W-1:0] REG_STATUS    = WB_ADR_W'(5);

    // bit positions in the control and status words
    localparam int CTRL_SUB_BIT    = 0;
    localparam int CTRL_CIN_BIT    = 1;
    localparam int STATUS_DONE_BIT = 0;

endpackage

/* run.sh */
#!/bin/sh
# Compile with Verilator and run; passes only if the testbench prints its pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_wb_adder -f files.f || exit 1

out=$(./obj_dir/Vtb_wb_adder +verilator+error+limit+1000 2>&1)
echo "$out"

echo "$out" | grep -q "^TESTBENCH PASSED$" && echo "simulation ok" || {
    echo "simulation failed"
    exit 1
}

/* verif/tb_wb_adder.sv */
`timescale 1ns/10ps
// testbench for the wishbone adder, runs bus cycles and checks read-back values
// against the add/sub rule; bound assertions watch handshake and datapath

module tb_wb_adder
    import adder_pkg::*;
    import wb_pkg::*;
();

    localparam int CLK_PERIOD      = 8;
    localparam int DRIVE_DELAY     = 1;   // after the rising edge
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_RANDOM      = 50;  // per operation type
    localparam int NUM_OPS         = 2 * NUM_RANDOM + 16;  // directed and register checks too
    localparam int WATCHDOG_CYCLES = NUM_OPS * 20 + 100;

    logic        clk = 1'b0;
    logic        arst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic [31:0] rng_state = 32'h31f5;

    wb_adder_top i_dut (
        .clk    (clk),
        .arst_n (arst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // sum and flags from the arithmetic rule
    function automatic add_res_t expected_result(input logic sub, input logic cin,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic [ADD_WIDTH-1:0] b_eff;
        logic                 c;
        logic [ADD_WIDTH:0]   total;
        add_res_t             r;
        b_eff = sub ? ~b : b;
        c     = sub ? 1'b1 : cin;  // subtract ignores the carry-in
        total = {1'b0, a} + {1'b0, b_eff} + {{ADD_WIDTH{1'b0}}, c};
        r.sum            = total[ADD_WIDTH-1:0];
        r.flags.carry    = total[ADD_WIDTH];
        r.flags.overflow = (a[31] == b_eff[31]) && (r.sum[31] != a[31]);
        r.flags.zero     = (r.sum == '0);
        r.flags.negative = r.sum[31];
        return r;
    endfunction

    function automatic logic [31:0] ctrl_word(input logic sub, input logic cin);
        logic [31:0] w;
        w = '0;
        w[CTRL_SUB_BIT] = sub;
        w[CTRL_CIN_BIT] = cin;
        return w;
    endfunction

    task automatic fail_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_asserts();
        if (i_dut.i_regs.i_asserts.fail_count != 0) begin
            $display("bound assertions failed %0d times", i_dut.i_regs.i_asserts.fail_count);
            fail_run();
        end
    endtask

    // wait for ack, take the data, release the bus after the ack edge
    task automatic finish_cycle(output logic [31:0] data);
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
        end while (!wb_rsp.ack);
        data = wb_rsp.dat;
        @(posedge clk);
        #DRIVE_DELAY;
        wb_req = '0;
    endtask

    task automatic bus_write(input logic [WB_ADR_W-1:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        finish_cycle(unused);
    endtask

    task automatic bus_read(input logic [WB_ADR_W-1:0] adr, output logic [31:0] dat);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'h0};
        finish_cycle(dat);
    endtask

    // one launch with read-back of result, flags and done
    task automatic run_op(input logic sub, input logic cin,
                          input logic [31:0] a, input logic [31:0] b);
        add_res_t    exp;
        logic [31:0] rd;
        exp = expected_result(sub, cin, a, b);
        bus_write(REG_OPERAND_A, a);
        bus_write(REG_OPERAND_B, b);
        bus_write(REG_CTRL, ctrl_word(sub, cin));
        bus_read(REG_RESULT, rd);
        check_value("RESULT", exp.sum, rd);
        bus_read(REG_FLAGS, rd);
        check_value("FLAGS", {{(32 - $bits(add_flags_t)){1'b0}}, exp.flags}, rd);
        bus_read(REG_STATUS, rd);
        check_value("STATUS", 32'h1 << STATUS_DONE_BIT, rd);
        check_asserts();
    endtask

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        fail_run();
    end

    initial begin : stimulus
        logic [31:0] rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        add_res_t    exp;
        arst_n = 1'b0;
        wb_req = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;

        // every address reads zero out of reset, done included
        for (int i = 0; i < (1 << WB_ADR_W); i++) begin
            bus_read(WB_ADR_W'(i), rd);
            check_value($sformatf("reset read adr %0d", i), 32'h0, rd);
        end

        run_op(1'b0, 1'b0, 32'h0, 32'h0);
        run_op(1'b0, 1'b1, 32'h0, 32'h0);
        run_op(1'b0, 1'b0, 32'hffff_ffff, 32'h1);  // carry out and zero
        run_op(1'b0, 1'b0, 32'h7fff_ffff, 32'h1);  // overflow
        run_op(1'b0, 1'b1, 32'hffff_ffff, 32'h0);
        repeat (NUM_RANDOM) begin
            a = lcg_next();
            b = lcg_next();
            r = lcg_next();
            run_op(1'b0, r[31], a, b);
        end

        run_op(1'b1, 1'b0, 32'h0bad_cafe, 32'h0bad_cafe);  // zero, no borrow
        run_op(1'b1, 1'b0, 32'h5, 32'h9);                  // negative with borrow
        run_op(1'b1, 1'b0, 32'h8000_0000, 32'h1);          // overflow
        run_op(1'b1, 1'b1, 32'd100, 32'd37);               // carry-in has no effect
        repeat (NUM_RANDOM) begin
            a = lcg_next();
            b = lcg_next();
            r = lcg_next();
            run_op(1'b1, r[31], a, b);
        end

        // register behavior
        bus_write(REG_OPERAND_A, 32'h1234_5678);
        bus_write(REG_OPERAND_B, 32'h9abc_def0);
        bus_read(REG_OPERAND_A, rd);
        check_value("OPERAND_A", 32'h1234_5678, rd);
        bus_read(REG_OPERAND_B, rd);
        check_value("OPERAND_B", 32'h9abc_def0, rd);
        exp = expected_result(1'b1, 1'b0, a, b);  // last random subtract still held
        bus_write(REG_RESULT, ~exp.sum);    // read-only
        bus_write(3'd6, 32'hffff_ffff);     // unmapped
        bus_read(REG_RESULT, rd);
        check_value("RESULT after ignored write", exp.sum, rd);
        bus_read(REG_OPERAND_A, rd);
        check_value("OPERAND_A after unmapped write", 32'h1234_5678, rd);
        bus_read(3'd6, rd);
        check_value("unmapped adr 6", 32'h0, rd);
        bus_read(3'd7, rd);
        check_value("unmapped adr 7", 32'h0, rd);
        bus_read(REG_CTRL, rd);
        check_value("CTRL", 32'h0, rd);

        // back-to-back launches on the same operands
        bus_write(REG_OPERAND_A, 32'h0000_1000);
        bus_write(REG_OPERAND_B, 32'h0000_0001);
        bus_write(REG_CTRL, ctrl_word(1'b0, 1'b0));
        bus_read(REG_RESULT, rd);
        exp = expected_result(1'b0, 1'b0, 32'h0000_1000, 32'h0000_0001);
        check_value("RESULT first launch", exp.sum, rd);
        bus_write(REG_CTRL, ctrl_word(1'b1, 1'b0));
        bus_read(REG_RESULT, rd);
        exp = expected_result(1'b1, 1'b0, 32'h0000_1000, 32'h0000_0001);
        check_value("RESULT second launch", exp.sum, rd);
        bus_read(REG_STATUS, rd);
        check_value("STATUS second launch", 32'h1 << STATUS_DONE_BIT, rd);
        bus_write(REG_CTRL, ctrl_word(1'b0, 1'b1));
        bus_read(REG_STATUS, rd);
        check_value("STATUS third launch", 32'h1 << STATUS_DONE_BIT, rd);
        bus_read(REG_RESULT, rd);
        exp = expected_result(1'b0, 1'b1, 32'h0000_1000, 32'h0000_0001);
        check_value("RESULT third launch", exp.sum, rd);

        repeat (4) @(posedge clk);
        if (i_dut.i_regs.i_asserts.fail_count != 0) begin
            $display("bound assertions failed %0d times", i_dut.i_regs.i_asserts.fail_count);
            fail_run();
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* verif/wb_adder_asserts.sv */
`timescale 1ns/10ps
// bus handshake and add/sub rule checks, bound into wb_adder_regs
// sees the datapath boundary through start, cmd, res and res_valid

module wb_adder_asserts
    import adder_pkg::*;
    import wb_pkg::*;
(
    input logic     clk,
    input logic     arst_n,
    input wb_req_t  wb_req,
    input logic     ack,
    input logic     start,
    input add_cmd_t cmd,
    input add_res_t res,
    input logic     res_valid,
    input logic     done
);

    int unsigned ack_fails;
    int unsigned valid_fails;
    int unsigned res_fails;
    int unsigned done_fails;
    int unsigned fail_count;

    assign fail_count = ack_fails + valid_fails + res_fails + done_fails;

    // sum and flags as the arithmetic rule defines them
    function automatic add_res_t rule_res(input add_cmd_t c);
        logic                 sub;
        logic                 cin;
        logic [ADD_WIDTH-1:0] b_eff;
        logic [ADD_WIDTH:0]   total;
        add_res_t             r;
        sub   = (c.op == OP_SUB);
        cin   = sub ? 1'b1 : c.carry_in;
        b_eff = sub ? ~c.b : c.b;
        total = {1'b0, c.a} + {1'b0, b_eff} + {{ADD_WIDTH{1'b0}}, cin};
        r.sum            = total[ADD_WIDTH-1:0];
        r.flags.carry    = total[ADD_WIDTH];
        r.flags.overflow = (c.a[ADD_WIDTH-1] == b_eff[ADD_WIDTH-1]) &&
                           (r.sum[ADD_WIDTH-1] != c.a[ADD_WIDTH-1]);
        r.flags.zero     = (r.sum == '0);
        r.flags.negative = r.sum[ADD_WIDTH-1];
        return r;
    endfunction

    ack_single: assert property (@(posedge clk) disable iff (!arst_n) ack |=> !ack)
        else begin
            ack_fails++;
            $error("ack stayed high for two cycles");
        end

    // ack only answers a live request
    ack_on_request: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ack) |-> $past(wb_req.cyc && wb_req.stb) && wb_req.cyc && wb_req.stb)
        else begin
            ack_fails++;
            $error("ack rose without cyc and stb");
        end

    valid_after_start: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid == $past(start))
        else begin
            valid_fails++;
            $error("res_valid does not follow start by one cycle");
        end

    res_rule: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid |-> (res == rule_res($past(cmd))))
        else begin
            res_fails++;
            $error("registered result breaks the add/sub rule");
        end

    done_cleared: assert property (@(posedge clk) disable iff (!arst_n) start |-> !done)
        else begin
            done_fails++;
            $error("done still set while a launch is pending");
        end

    done_set: assert property (@(posedge clk) disable iff (!arst_n) $past(start, 2) |-> done)
        else begin
            done_fails++;
            $error("done not set two edges after start");
        end

endmodule

bind wb_adder_regs wb_adder_asserts i_asserts (
    .clk       (clk),
    .arst_n    (arst_n),
    .wb_req    (wb_req),
    .ack       (ack),
    .start     (start),
    .cmd       (cmd),
    .res       (res),
    .res_valid (res_valid),
    .done      (done)
);
